//--- verilog/drawPkg.sv
`default_nettype none

package drawPkg;

	// Display size in pixels
	localparam int ScreenWidth = 160;
	localparam int ScreenHeight = 120;

	// Coordinate widths
	localparam int XBits = 8;
	localparam int YBits = 7;

	// Linear frame buffer word address, y * width + x
	localparam int AddrBits = 15;

	// 3-bit colour, one bit per channel
	localparam int ColorBits = 3;

	// Raster position, x in the upper bits
	typedef struct packed {
		logic [XBits-1:0] x;
		logic [YBits-1:0] y;
	} coordT;

	typedef logic [ColorBits-1:0] colorT;

	// Pixel as it leaves the pattern table
	typedef struct packed {
		coordT coord;
		colorT color;
	} pixelT;

endpackage

`default_nettype wire

//--- verilog/seqPkg.sv
`default_nettype none

package seqPkg;

	// Screen codes
	// Code value also seeds the pattern colour
	typedef enum logic [2:0] {
		ScrClear = 3'd0,
		ScrTitle1 = 3'd1,
		ScrTitle2 = 3'd2,
		ScrTitle3 = 3'd3,
		ScrScene1 = 3'd4,
		ScrScene2 = 3'd5
	} screenT;

	// Sequencer FSM states
	typedef enum logic [2:0] {
		SReset,
		SLoad,
		SDraw,
		SDwell
	} seqStateT;

	// Clock cycles a finished screen stays up
	localparam int DwellCycles = 64;

endpackage

`default_nettype wire

//--- verilog/screenSequencer.sv
`default_nettype none

module screenSequencer (
	input  logic           clk,
	input  logic           rstN,
	input  logic           userCont,
	input  logic           frameDone,
	input  logic           drawIdle,
	output logic           frameStart,
	output seqPkg::screenT screen
);

	seqPkg::seqStateT state;
	seqPkg::seqStateT nextState;
	seqPkg::screenT nextScreen;

	// Dwell timer
	logic [$clog2(seqPkg::DwellCycles)-1:0] dwellCount;
	logic dwellLast;

	// Last coordinate already left the scanner
	logic doneSeen;
	// Continue pressed during this title dwell
	logic contSeen;
	logic isTitle;
	logic goScene;

	assign dwellLast = (32'(dwellCount) == seqPkg::DwellCycles - 1);

	assign isTitle = (screen == seqPkg::ScrTitle1) || (screen == seqPkg::ScrTitle2) ||
		(screen == seqPkg::ScrTitle3);

	// Late press in the final dwell cycle still counts
	assign goScene = contSeen || (isTitle && userCont);

	// Next state
	always_comb begin
		nextState = state;
		case (state)
			seqPkg::SReset: nextState = seqPkg::SLoad;
			// One cycle to start the scan
			seqPkg::SLoad: nextState = seqPkg::SDraw;
			// Wait for the last pixel to leave the bus
			seqPkg::SDraw: if (doneSeen && drawIdle) nextState = seqPkg::SDwell;
			seqPkg::SDwell: if (dwellLast) nextState = seqPkg::SLoad;
			default: nextState = seqPkg::SReset;
		endcase
	end

	// Screen order
	always_comb begin
		case (screen)
			seqPkg::ScrTitle1: nextScreen = seqPkg::ScrTitle2;
			seqPkg::ScrTitle2: nextScreen = seqPkg::ScrTitle3;
			seqPkg::ScrScene1: nextScreen = seqPkg::ScrScene2;
			// Clear, title3 and scene2 all go back to title1
			default: nextScreen = seqPkg::ScrTitle1;
		endcase
		if (goScene) begin
			nextScreen = seqPkg::ScrScene1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= seqPkg::SReset;
			screen <= seqPkg::ScrClear;
			frameStart <= 1'b0;
			doneSeen <= 1'b0;
			contSeen <= 1'b0;
			dwellCount <= '0;
		end else begin
			state <= nextState;
			// Strobe lines up with the single SLoad cycle
			frameStart <= (nextState == seqPkg::SLoad);

			if (state == seqPkg::SLoad) begin
				doneSeen <= 1'b0;
			end else if (frameDone) begin
				doneSeen <= 1'b1;
			end

			// Counter sits at zero outside the dwell
			if (state == seqPkg::SDwell) begin
				dwellCount <= dwellCount + 1'b1;
				if (isTitle && userCont) begin
					contSeen <= 1'b1;
				end
			end else begin
				dwellCount <= '0;
				contSeen <= 1'b0;
			end

			// New screen is ready by the SLoad cycle
			if (state == seqPkg::SDwell && dwellLast) begin
				screen <= nextScreen;
			end
		end
	end

	// Frame start only from the load state
	assert property (@(posedge clk) disable iff (!rstN)
		frameStart |-> state == seqPkg::SLoad);

	// Pattern must not switch mid frame
	assert property (@(posedge clk) disable iff (!rstN)
		state == seqPkg::SDraw |=> state != seqPkg::SDraw || $stable(screen));

endmodule

`default_nettype wire

//--- verilog/pixelScanner.sv
`default_nettype none

module pixelScanner (
	input  logic          clk,
	input  logic          rstN,
	input  logic          frameStart,
	output drawPkg::coordT coord,
	output logic          coordValid,
	input  logic          coordReady,
	output logic          frameDone
);

	logic accept;
	logic xLast;
	logic yLast;

	assign accept = coordValid && coordReady;
	assign xLast = (coord.x == drawPkg::XBits'(drawPkg::ScreenWidth - 1));
	assign yLast = (coord.y == drawPkg::YBits'(drawPkg::ScreenHeight - 1));

	// Pulses as the bottom-right pixel is taken
	assign frameDone = accept && xLast && yLast;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			coordValid <= 1'b0;
		end else if (frameStart) begin
			coordValid <= 1'b1;
		end else if (frameDone) begin
			coordValid <= 1'b0;
		end
	end

	// Raster counters
	// x fastest, y steps on x wrap
	always_ff @(posedge clk) begin
		if (frameStart) begin
			coord <= '0;
		end else if (accept) begin
			if (xLast) begin
				coord.x <= '0;
				// Wraps past the last row too, unused once valid drops
				coord.y <= coord.y + 1'b1;
			end else begin
				coord.x <= coord.x + 1'b1;
			end
		end
	end

	// Stalled coordinate held until taken
	assert property (@(posedge clk) disable iff (!rstN)
		coordValid && !coordReady |=> coordValid && $stable(coord));

endmodule

`default_nettype wire

//--- verilog/patternRom.sv
`default_nettype none

module patternRom (
	input  logic           clk,
	input  logic           rstN,
	input  seqPkg::screenT screen,
	input  drawPkg::coordT coord,
	input  logic           coordValid,
	output logic           coordReady,
	output drawPkg::pixelT pix,
	output logic           pixValid,
	input  logic           pixReady,
	output logic           empty
);

	// Colour rule per screen
	function automatic drawPkg::colorT patternColor(input seqPkg::screenT scr,
		input drawPkg::coordT c);
		logic [drawPkg::XBits:0] diag;
		diag = c.x + c.y;
		case (scr)
			// Horizontal bands four rows high
			seqPkg::ScrTitle1, seqPkg::ScrTitle2, seqPkg::ScrTitle3:
				patternColor = drawPkg::colorT'(scr) ^ c.y[4:2];
			// Diagonal stripes
			seqPkg::ScrScene1, seqPkg::ScrScene2:
				patternColor = drawPkg::colorT'(scr) ^ diag[3:1];
			// Clear frame is all black
			default:
				patternColor = '0;
		endcase
	endfunction

	// One-entry stage, refills as the entry leaves
	assign coordReady = !pixValid || pixReady;
	assign empty = !pixValid;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pixValid <= 1'b0;
		end else if (coordValid && coordReady) begin
			pixValid <= 1'b1;
		end else if (pixReady) begin
			pixValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (coordValid && coordReady) begin
			pix.coord <= coord;
			pix.color <= patternColor(screen, coord);
		end
	end

endmodule

`default_nettype wire

//--- verilog/wbPixelWriter.sv
`default_nettype none

module wbPixelWriter (
	input  logic                         clk,
	input  logic                         rstN,
	input  drawPkg::pixelT               pix,
	input  logic                         pixValid,
	output logic                         pixReady,
	output logic                         busIdle,
	output logic                         wbCyc,
	output logic                         wbStb,
	output logic                         wbWe,
	output logic [drawPkg::AddrBits-1:0] wbAdr,
	output drawPkg::colorT               wbDat,
	input  logic                         wbAck
);

	// Held pixel is the open bus cycle
	assign busIdle = !wbCyc;
	// No new pixel until the cycle has dropped
	assign pixReady = !wbCyc;

	// Write-only master
	assign wbWe = wbStb;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
		end else if (pixValid && pixReady) begin
			wbCyc <= 1'b1;
			wbStb <= 1'b1;
		end else if (wbStb && wbAck) begin
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
		end
	end

	// Linear address, y * 160 + x
	always_ff @(posedge clk) begin
		if (pixValid && pixReady) begin
			wbAdr <= drawPkg::AddrBits'(pix.coord.y) * drawPkg::AddrBits'(drawPkg::ScreenWidth) +
				drawPkg::AddrBits'(pix.coord.x);
			wbDat <= pix.color;
		end
	end

	// Strobe only inside a cycle
	assert property (@(posedge clk) disable iff (!rstN)
		$rose(wbStb) |-> wbCyc);

endmodule

`default_nettype wire

//--- verilog/screenDrawTop.sv
`default_nettype none

module screenDrawTop (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic                         userCont,
	output logic                         wbCyc,
	output logic                         wbStb,
	output logic                         wbWe,
	output logic [drawPkg::AddrBits-1:0] wbAdr,
	output drawPkg::colorT               wbDat,
	input  logic                         wbAck,
	output seqPkg::screenT               screen
);

	logic frameStart;
	logic frameDone;
	logic drawIdle;

	// Scanner to pattern table
	drawPkg::coordT coord;
	logic coordValid;
	logic coordReady;

	// Pattern table to bus writer
	drawPkg::pixelT pix;
	logic pixValid;
	logic pixReady;
	logic romEmpty;
	logic busIdle;

	// Both pipeline stages drained
	assign drawIdle = busIdle && romEmpty;

	screenSequencer sequencer (
		.clk(clk),
		.rstN(rstN),
		.userCont(userCont),
		.frameDone(frameDone),
		.drawIdle(drawIdle),
		.frameStart(frameStart),
		.screen(screen)
	);

	pixelScanner scanner (
		.clk(clk),
		.rstN(rstN),
		.frameStart(frameStart),
		.coord(coord),
		.coordValid(coordValid),
		.coordReady(coordReady),
		.frameDone(frameDone)
	);

	patternRom rom (
		.clk(clk),
		.rstN(rstN),
		.screen(screen),
		.coord(coord),
		.coordValid(coordValid),
		.coordReady(coordReady),
		.pix(pix),
		.pixValid(pixValid),
		.pixReady(pixReady),
		.empty(romEmpty)
	);

	wbPixelWriter writer (
		.clk(clk),
		.rstN(rstN),
		.pix(pix),
		.pixValid(pixValid),
		.pixReady(pixReady),
		.busIdle(busIdle),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDat(wbDat),
		.wbAck(wbAck)
	);

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`default_nettype none

module clockGen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period, starts low
	initial clk = 1'b0;

	always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- tests/screenDrawTb.sv
`default_nettype none

module screenDrawTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FramePixels = drawPkg::ScreenWidth * drawPkg::ScreenHeight;
	// Ten frames at up to 6 cycles a pixel, dwells, then 30 percent margin
	localparam int FrameBudget = FramePixels * 6 + seqPkg::DwellCycles;
	localparam int TimeoutCycles = 10 * FrameBudget * 13 / 10;

	// One write as the slave saw it when acking
	typedef struct packed {
		logic [31:0] cycle;
		seqPkg::screenT scr;
		logic [drawPkg::AddrBits-1:0] adr;
		drawPkg::colorT dat;
	} writeT;

	logic clk;
	logic rstN;
	logic userCont;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [drawPkg::AddrBits-1:0] wbAdr;
	drawPkg::colorT wbDat;
	logic wbAck = 1'b0;
	seqPkg::screenT screen;

	// Slave model state
	writeT writes[$];
	logic [15:0] lfsr = 16'd88;
	logic busy = 1'b0;
	int waitLeft = 0;
	logic [drawPkg::AddrBits-1:0] heldAdr;
	drawPkg::colorT heldDat;
	int stallCycles = 0;

	int unsigned cycleCount = 0;
	logic [31:0] lastCycle = '0;

	clockGen clockSource (
		.clk(clk)
	);

	screenDrawTop DUT (
		.clk(clk),
		.rstN(rstN),
		.userCont(userCont),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDat(wbDat),
		.wbAck(wbAck),
		.screen(screen)
	);

	task automatic checkValue(input string testName, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s, %s: expected %0d, actual %0d", testName, what,
				expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic failWith(input string why);
		$display("Failure: %s", why);
		$display("=== FAIL ===");
		$fatal(1, why);
	endtask

	// Galois LFSR, taps 16,14,13,11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Two bits, one step each
	task automatic drawWaitCount(output int n);
		n = 0;
		repeat (2) begin
			n = (n << 1) | int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
	endtask

	// Pattern rules of the display
	function automatic int expectedColor(input int code, input int x, input int y);
		if (code >= 1 && code <= 3) begin
			return code ^ ((y >> 2) & 7);
		end
		if (code >= 4) begin
			return code ^ (((x + y) >> 1) & 7);
		end
		return 0;
	endfunction

	// Run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	// Wishbone slave, 0 to 3 wait states per strobe
	always @(posedge clk) begin : slaveModel
		logic inReset;
		writeT rec;
		// rstN settled one edge ago
		inReset = !rstN;
		#1;
		if (inReset) begin
			wbAck = 1'b0;
			busy = 1'b0;
		end else begin
			checkValue("busProtocol", "wbCyc against wbStb", 32'(wbStb), 32'(wbCyc));
			checkValue("busProtocol", "wbWe against wbStb", 32'(wbStb), 32'(wbWe));
			if (wbAck) begin
				// Cycle must close right after the ack
				checkValue("busProtocol", "wbStb after ack", 0, 32'(wbStb));
				wbAck = 1'b0;
				busy = 1'b0;
			end else if (wbStb) begin
				if (!busy) begin
					busy = 1'b1;
					drawWaitCount(waitLeft);
					heldAdr = wbAdr;
					heldDat = wbDat;
				end else begin
					stallCycles++;
					checkValue("busProtocol", "held address", 32'(heldAdr), 32'(wbAdr));
					checkValue("busProtocol", "held data", 32'(heldDat), 32'(wbDat));
				end
				if (waitLeft == 0) begin
					rec.cycle = cycleCount;
					rec.scr = screen;
					rec.adr = wbAdr;
					rec.dat = wbDat;
					writes.push_back(rec);
					wbAck = 1'b1;
				end else begin
					waitLeft--;
				end
			end else if (busy) begin
				failWith("wbStb dropped before the slave acked");
			end
		end
	end

	task automatic nextWrite(output writeT w);
		while (writes.size() == 0) begin
			@(posedge clk);
			#2;
		end
		w = writes.pop_front();
	endtask

	// One full frame, raster order, pattern per screen code
	task automatic checkFrame(input string testName, input seqPkg::screenT code);
		writeT w;
		int x;
		int y;
		logic [31:0] gap;
		bit seen [FramePixels];
		foreach (seen[k]) begin
			seen[k] = 1'b0;
		end
		for (int i = 0; i < FramePixels; i++) begin
			nextWrite(w);
			// Dwell lies between the previous frame and this one
			if (i == 0 && lastCycle != 0) begin
				gap = w.cycle - lastCycle;
				if (gap <= seqPkg::DwellCycles || gap > seqPkg::DwellCycles + 12) begin
					failWith($sformatf("%s: gap of %0d cycles before the frame", testName, gap));
				end
			end
			if (int'(w.adr) >= FramePixels) begin
				failWith($sformatf("%s: write beyond the frame buffer", testName));
			end
			if (seen[w.adr]) begin
				failWith($sformatf("%s: address %0d written twice", testName, w.adr));
			end
			seen[w.adr] = 1'b1;
			x = i % drawPkg::ScreenWidth;
			y = i / drawPkg::ScreenWidth;
			checkValue(testName, "address", i, 32'(w.adr));
			checkValue(testName, "screen", 32'(code), 32'(w.scr));
			checkValue(testName, "data", expectedColor(int'(code), x, y), 32'(w.dat));
		end
		lastCycle = w.cycle;
	endtask

	task automatic resetTest;
		repeat (3) begin
			@(posedge clk);
			#1;
			checkValue("reset", "wbCyc", 0, 32'(wbCyc));
			checkValue("reset", "wbStb", 0, 32'(wbStb));
			checkValue("reset", "screen", 32'(seqPkg::ScrClear), 32'(screen));
		end
		rstN = 1'b1;
		// First cycle out of reset
		@(posedge clk);
		#1;
		checkValue("reset", "wbCyc", 0, 32'(wbCyc));
		checkValue("reset", "wbStb", 0, 32'(wbStb));
		checkValue("reset", "screen", 32'(seqPkg::ScrClear), 32'(screen));
	endtask

	task automatic clearFrameTest;
		checkFrame("clearFrame", seqPkg::ScrClear);
	endtask

	task automatic titleFramesTest;
		checkFrame("titleFrames", seqPkg::ScrTitle1);
		checkFrame("titleFrames", seqPkg::ScrTitle2);
		checkFrame("titleFrames", seqPkg::ScrTitle3);
	endtask

	task automatic titleContinueTest;
		checkFrame("titleContinue", seqPkg::ScrTitle1);
		@(posedge clk);
		#1;
		userCont = 1'b1;
		// Held through the dwell until the sequencer moves on
		do begin
			@(posedge clk);
			#1;
		end while (screen == seqPkg::ScrTitle1);
		userCont = 1'b0;
		checkFrame("titleContinue", seqPkg::ScrScene1);
	endtask

	task automatic sceneReturnTest;
		checkFrame("sceneReturn", seqPkg::ScrScene2);
		checkFrame("sceneReturn", seqPkg::ScrTitle1);
	endtask

	task automatic busProtocolTest;
		// Stability itself is checked by the slave on every wait
		if (stallCycles == 0) begin
			failWith("the slave never inserted a wait state");
		end
		// Bus stays closed through the dwell after the last frame
		repeat (seqPkg::DwellCycles) begin
			@(posedge clk);
			#2;
			checkValue("busProtocol", "wbCyc in the dwell", 0, 32'(wbCyc));
			checkValue("busProtocol", "writes in the dwell", 0, 32'(writes.size()));
		end
	endtask

	initial begin
		rstN = 1'b0;
		userCont = 1'b0;
		resetTest();
		clearFrameTest();
		titleFramesTest();
		titleContinueTest();
		sceneReturnTest();
		busProtocolTest();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- screenDraw.f
verilog/drawPkg.sv
verilog/seqPkg.sv
verilog/screenSequencer.sv
verilog/pixelScanner.sv
verilog/patternRom.sv
verilog/wbPixelWriter.sv
verilog/screenDrawTop.sv
tests/clockGen.sv
tests/screenDrawTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the screen sequencer with its testbench and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module screenDrawTb \
	-f screenDraw.f \
	-o screenDrawSim

# Exit status is nonzero when the testbench stops on $fatal
./obj_dir/screenDrawSim
